//--- cpu900_pkg.sv
// ------------------------------
// opcodes, states, flag bits and register-file sizes shared by the core
// ------------------------------
package cpu900_pkg;

    // upper five bits of the opcode byte, r in the lower three
    typedef enum logic [4:0] {
        OP_LD_IMM = 5'd0,   // LD r,#n
        OP_LD_REG = 5'd1,   // LD r,r'
        OP_ADD    = 5'd2,
        OP_SUB    = 5'd3,
        OP_AND    = 5'd4,
        OP_OR     = 5'd5,
        OP_XOR    = 5'd6,
        OP_INC    = 5'd7,
        OP_DEC    = 5'd8,
        OP_LD_MEM = 5'd9,   // LD r,(nn)
        OP_ST_MEM = 5'd10,  // ST (nn),r
        OP_JP     = 5'd11,
        OP_LDRFP  = 5'd12,
        OP_EXF    = 5'd13,
        OP_HALT   = 5'd14
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_PASS, ALU_ADD, ALU_SUB, ALU_AND,
        ALU_OR, ALU_XOR, ALU_INC, ALU_DEC
    } alu_op_e;

    typedef enum logic [2:0] {
        S_FETCH_OP, S_FETCH_ARG, S_FETCH_ADDR_LO, S_FETCH_ADDR_HI,
        S_EXEC, S_MEM_ACCESS, S_WRITEBACK, S_HALTED
    } ctrl_state_e;

    // flags byte is S Z 0 H 0 V N C
    localparam int FLAG_S = 7;
    localparam int FLAG_Z = 6;
    localparam int FLAG_H = 4;
    localparam int FLAG_V = 2;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 0;

    localparam int NUM_BANKS     = 4;
    localparam int REGS_PER_BANK = 8;

    localparam logic [5:0] DMP_FLAGS = 6'd32;
    localparam logic [5:0] DMP_RFP   = 6'd33;

endpackage

//--- cpu900_regs.sv
// ------------------------------
// banked byte registers, main and alternate flags, operand latches
// and the inspection dump port
// ------------------------------
`timescale 1ns/1ps
module cpu900_regs (
    input  logic       clk,
    input  logic       rst,
    input  logic       rf_we,
    input  logic [2:0] rf_wsel,
    input  logic [2:0] rf_asel,
    input  logic [2:0] rf_bsel,
    input  logic [7:0] rf_wdata,
    input  logic [7:0] flag_we,
    input  logic [7:0] flag_in,
    input  logic       exff,
    input  logic       rfp_we,
    input  logic [1:0] rfp_in,
    output logic [7:0] op_a,
    output logic [7:0] op_b,
    output logic [7:0] flags,
    input  logic [5:0] dmp_addr,
    output logic [7:0] dmp_dout
);
    localparam int RF_SIZE = cpu900_pkg::NUM_BANKS * cpu900_pkg::REGS_PER_BANK;

    logic [7:0] rf [0:RF_SIZE-1];
    logic [7:0] flg;        // main flags
    logic [7:0] flg_alt;    // alternate set, swapped in by EXF
    logic [1:0] rfp;        // current bank
    logic [4:0] widx;

    assign widx  = {rfp, rf_wsel};  // bank * 8 + r
    assign flags = flg;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < RF_SIZE; i++) begin
                rf[i] <= 8'h00;
            end
            flg     <= 8'h00;
            flg_alt <= 8'h00;
            rfp     <= 2'd0;
        end else begin
            if (rf_we) begin
                rf[widx] <= rf_wdata;
            end
            if (rfp_we) begin
                rfp <= rfp_in;
            end
            if (exff) begin
                flg     <= flg_alt;
                flg_alt <= flg;
            end else begin
                flg <= (flg & ~flag_we) | (flag_in & flag_we);  // per-flag update
            end
        end
    end

    // sampled every cycle, the selects are steady from EXEC on
    always_ff @(posedge clk) begin
        op_a <= rf[{rfp, rf_asel}];
        op_b <= rf[{rfp, rf_bsel}];
    end

    always_comb begin
        if (dmp_addr < 6'(RF_SIZE)) begin
            dmp_dout = rf[dmp_addr[4:0]];
        end else if (dmp_addr == cpu900_pkg::DMP_FLAGS) begin
            dmp_dout = flg;
        end else if (dmp_addr == cpu900_pkg::DMP_RFP) begin
            dmp_dout = {6'd0, rfp};
        end else begin
            dmp_dout = 8'h00;
        end
    end

endmodule

//--- cpu900_alu.sv
// ------------------------------
// byte ALU, result plus new flags and the mask of flags to write
// ------------------------------
`timescale 1ns/1ps
module cpu900_alu (
    input  cpu900_pkg::alu_op_e alu_op,
    input  logic [7:0]          a,
    input  logic [7:0]          b,
    input  logic                cin,
    output logic [7:0]          rslt,
    output logic [7:0]          flag_out,
    output logic [7:0]          flag_mask
);
    localparam logic [7:0] MASK_ALL = 8'b1101_0111;  // S Z H V N C
    localparam logic [7:0] MASK_NOC = 8'b1101_0110;  // carry kept

    logic [8:0] wide;   // result with carry or borrow out
    logic [7:0] hx;     // half carry shows in bit 4
    logic       hf;
    logic       vf;
    logic       nf;
    logic       cf;

    always_comb begin
        wide      = {1'b0, b};
        hx        = 8'h00;
        hf        = 1'b0;
        vf        = 1'b0;
        nf        = 1'b0;
        cf        = cin;
        flag_mask = 8'h00;
        case (alu_op)
            cpu900_pkg::ALU_ADD: begin
                wide      = {1'b0, a} + {1'b0, b};
                hx        = a ^ b ^ wide[7:0];
                hf        = hx[4];
                vf        = (a[7] == b[7]) && (wide[7] != a[7]);
                cf        = wide[8];
                flag_mask = MASK_ALL;
            end
            cpu900_pkg::ALU_SUB: begin
                wide      = {1'b0, a} - {1'b0, b};
                hx        = a ^ b ^ wide[7:0];
                hf        = hx[4];
                vf        = (a[7] != b[7]) && (wide[7] != a[7]);
                nf        = 1'b1;
                cf        = wide[8];  // borrow
                flag_mask = MASK_ALL;
            end
            cpu900_pkg::ALU_INC: begin
                wide      = {1'b0, a + 8'd1};
                hf        = a[3:0] == 4'hf;
                vf        = a == 8'h7f;
                flag_mask = MASK_NOC;
            end
            cpu900_pkg::ALU_DEC: begin
                wide      = {1'b0, a - 8'd1};
                hf        = a[3:0] == 4'h0;
                vf        = a == 8'h80;
                nf        = 1'b1;
                flag_mask = MASK_NOC;
            end
            cpu900_pkg::ALU_AND, cpu900_pkg::ALU_OR, cpu900_pkg::ALU_XOR: begin
                if (alu_op == cpu900_pkg::ALU_AND) begin
                    wide = {1'b0, a & b};
                    hf   = 1'b1;
                end else if (alu_op == cpu900_pkg::ALU_OR) begin
                    wide = {1'b0, a | b};
                end else begin
                    wide = {1'b0, a ^ b};
                end
                vf        = ~^wide[7:0];  // even parity
                cf        = 1'b0;
                flag_mask = MASK_ALL;
            end
            default: ;  // PASS hands b through
        endcase
        rslt                         = wide[7:0];
        flag_out                     = 8'h00;
        flag_out[cpu900_pkg::FLAG_S] = rslt[7];
        flag_out[cpu900_pkg::FLAG_Z] = rslt == 8'h00;
        flag_out[cpu900_pkg::FLAG_H] = hf;
        flag_out[cpu900_pkg::FLAG_V] = vf;
        flag_out[cpu900_pkg::FLAG_N] = nf;
        flag_out[cpu900_pkg::FLAG_C] = cf;
    end

endmodule

//--- cpu900_fetch.sv
// ------------------------------
// program counter and two-byte prefetch queue, reads through the arbiter
// ------------------------------
`timescale 1ns/1ps
module cpu900_fetch #(
    parameter int ADDR_W = 16
) (
    input  logic              clk,
    input  logic              rst,
    output logic              fetch_req,
    output logic [ADDR_W-1:0] fetch_addr,
    input  logic              fetch_ack,
    input  logic [7:0]        rdata,
    output logic              q_valid,
    output logic [7:0]        q_byte,
    input  logic              q_pop,
    input  logic              flush,
    input  logic [ADDR_W-1:0] new_pc
);
    logic [ADDR_W-1:0] pc;
    logic [7:0]        q [0:1];
    logic [1:0]        cnt;     // bytes held
    logic              drop;    // read on the bus belongs to a flushed stream
    logic              push;
    logic              start;
    logic              widx;

    assign push    = fetch_ack && !drop && !flush;
    assign start   = !fetch_req && !flush && cnt != 2'd2;
    assign widx    = cnt[0] && !q_pop;  // slot after a possible pop
    assign q_valid = cnt != 2'd0;
    assign q_byte  = q[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc        <= '0;
            cnt       <= 2'd0;
            fetch_req <= 1'b0;
            drop      <= 1'b0;
        end else begin
            if (flush) begin
                pc  <= new_pc;
                cnt <= 2'd0;
            end else begin
                if (push) begin
                    pc <= pc + 1'b1;
                end
                cnt <= cnt + 2'(push) - 2'(q_pop);
            end
            if (fetch_req) begin
                if (fetch_ack) begin
                    fetch_req <= 1'b0;
                    drop      <= 1'b0;
                end else if (flush) begin
                    drop <= 1'b1;   // finish the read, ignore its byte
                end
            end else if (start) begin
                fetch_req <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            fetch_addr <= pc;  // held until the ack
        end
        if (q_pop) begin
            q[0] <= q[1];
        end
        if (push) begin
            q[widx] <= rdata;
        end
    end

endmodule

//--- cpu900_ctrl.sv
// ------------------------------
// decode and execute FSM, pulls bytes from the prefetch queue and
// owns the data port of the memory bus
// ------------------------------
`timescale 1ns/1ps
module cpu900_ctrl #(
    parameter int ADDR_W = 16
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                q_valid,
    input  logic [7:0]          q_byte,
    output logic                q_pop,
    output logic                flush,
    output logic [ADDR_W-1:0]   new_pc,
    output logic                data_rd,
    output logic                data_wr,
    output logic [ADDR_W-1:0]   data_addr,
    output logic [7:0]          data_wdata,
    input  logic                data_ack,
    input  logic [7:0]          rdata,
    output logic                rf_we,
    output logic [2:0]          rf_wsel,
    output logic [2:0]          rf_asel,
    output logic [2:0]          rf_bsel,
    output logic [7:0]          rf_wdata,
    output logic [7:0]          flag_we,
    output cpu900_pkg::alu_op_e alu_op,
    input  logic [7:0]          rslt,
    input  logic [7:0]          flag_mask,
    output logic                exff,
    output logic                rfp_we,
    output logic [1:0]          rfp_in,
    output logic                halted
);
    cpu900_pkg::ctrl_state_e state;
    cpu900_pkg::opcode_e     op;
    cpu900_pkg::opcode_e     q_op;
    logic [2:0]              r;
    logic [7:0]              arg;       // immediate, source reg or load data
    logic [ADDR_W-1:0]       addr_q;

    assign q_op = cpu900_pkg::opcode_e'(q_byte[7:3]);
    assign q_pop = q_valid && state inside {cpu900_pkg::S_FETCH_OP, cpu900_pkg::S_FETCH_ARG,
        cpu900_pkg::S_FETCH_ADDR_LO, cpu900_pkg::S_FETCH_ADDR_HI};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= cpu900_pkg::S_FETCH_OP;
            op      <= cpu900_pkg::OP_HALT;
            r       <= 3'd0;
            data_rd <= 1'b0;
            data_wr <= 1'b0;
        end else begin
            case (state)
                cpu900_pkg::S_FETCH_OP: if (q_valid) begin
                    op <= q_op;
                    r  <= q_byte[2:0];
                    case (q_op)
                        cpu900_pkg::OP_INC, cpu900_pkg::OP_DEC, cpu900_pkg::OP_EXF:
                            state <= cpu900_pkg::S_EXEC;
                        cpu900_pkg::OP_LD_MEM, cpu900_pkg::OP_ST_MEM, cpu900_pkg::OP_JP:
                            state <= cpu900_pkg::S_FETCH_ADDR_LO;
                        cpu900_pkg::OP_HALT:
                            state <= cpu900_pkg::S_HALTED;
                        default:
                            state <= cpu900_pkg::S_FETCH_ARG;
                    endcase
                end
                cpu900_pkg::S_FETCH_ARG:
                    if (q_valid) state <= cpu900_pkg::S_EXEC;
                cpu900_pkg::S_FETCH_ADDR_LO:
                    if (q_valid) state <= cpu900_pkg::S_FETCH_ADDR_HI;
                cpu900_pkg::S_FETCH_ADDR_HI:
                    if (q_valid) state <= cpu900_pkg::S_EXEC;
                cpu900_pkg::S_EXEC: begin
                    if (op == cpu900_pkg::OP_LD_MEM || op == cpu900_pkg::OP_ST_MEM) begin
                        data_rd <= op == cpu900_pkg::OP_LD_MEM;
                        data_wr <= op == cpu900_pkg::OP_ST_MEM;
                        state   <= cpu900_pkg::S_MEM_ACCESS;
                    end else if (op inside {[cpu900_pkg::OP_LD_REG:cpu900_pkg::OP_DEC]}) begin
                        state <= cpu900_pkg::S_WRITEBACK;  // ALU on latched operands
                    end else begin
                        state <= cpu900_pkg::S_FETCH_OP;
                    end
                end
                cpu900_pkg::S_MEM_ACCESS: if (data_ack) begin
                    data_rd <= 1'b0;
                    data_wr <= 1'b0;
                    state   <= (op == cpu900_pkg::OP_LD_MEM) ? cpu900_pkg::S_WRITEBACK
                                                             : cpu900_pkg::S_FETCH_OP;
                end
                cpu900_pkg::S_WRITEBACK:
                    state <= cpu900_pkg::S_FETCH_OP;
                default:
                    state <= cpu900_pkg::S_HALTED;  // parked until reset
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cpu900_pkg::S_FETCH_ARG && q_valid) begin
            arg <= q_byte;
        end
        if (state == cpu900_pkg::S_MEM_ACCESS && data_ack) begin
            arg <= rdata;
        end
        if (state == cpu900_pkg::S_FETCH_ADDR_LO && q_valid) begin
            addr_q[7:0] <= q_byte;
        end
        if (state == cpu900_pkg::S_FETCH_ADDR_HI && q_valid) begin
            addr_q <= ADDR_W'({q_byte, addr_q[7:0]});  // low byte came first
        end
    end

    always_comb begin
        case (op)
            cpu900_pkg::OP_ADD: alu_op = cpu900_pkg::ALU_ADD;
            cpu900_pkg::OP_SUB: alu_op = cpu900_pkg::ALU_SUB;
            cpu900_pkg::OP_AND: alu_op = cpu900_pkg::ALU_AND;
            cpu900_pkg::OP_OR:  alu_op = cpu900_pkg::ALU_OR;
            cpu900_pkg::OP_XOR: alu_op = cpu900_pkg::ALU_XOR;
            cpu900_pkg::OP_INC: alu_op = cpu900_pkg::ALU_INC;
            cpu900_pkg::OP_DEC: alu_op = cpu900_pkg::ALU_DEC;
            default:            alu_op = cpu900_pkg::ALU_PASS;
        endcase
    end

    assign rf_wsel    = r;
    assign rf_asel    = r;
    assign rf_bsel    = (op == cpu900_pkg::OP_ST_MEM) ? r : arg[2:0];
    assign rf_we      = (state == cpu900_pkg::S_EXEC && op == cpu900_pkg::OP_LD_IMM) ||
                        state == cpu900_pkg::S_WRITEBACK;
    assign rf_wdata   = (op == cpu900_pkg::OP_LD_IMM || op == cpu900_pkg::OP_LD_MEM) ? arg : rslt;
    assign flag_we    = (state == cpu900_pkg::S_WRITEBACK) ? flag_mask : 8'h00;
    assign exff       = state == cpu900_pkg::S_EXEC && op == cpu900_pkg::OP_EXF;
    assign rfp_we     = state == cpu900_pkg::S_EXEC && op == cpu900_pkg::OP_LDRFP;
    assign rfp_in     = arg[1:0];
    assign flush      = state == cpu900_pkg::S_EXEC && op == cpu900_pkg::OP_JP;
    assign new_pc     = addr_q;
    assign data_addr  = addr_q;
    assign data_wdata = rslt;   // store source passed through the ALU
    assign halted     = state == cpu900_pkg::S_HALTED;

endmodule

//--- cpu900_bus_arb.sv
// ------------------------------
// fixed-priority memory bus arbiter, data ahead of fetch
// ------------------------------
`timescale 1ns/1ps
module cpu900_bus_arb #(
    parameter int ADDR_W = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              fetch_req,
    input  logic [ADDR_W-1:0] fetch_addr,
    output logic              fetch_ack,
    input  logic              data_rd,
    input  logic              data_wr,
    input  logic [ADDR_W-1:0] data_addr,
    input  logic [7:0]        data_wdata,
    output logic              data_ack,
    output logic [ADDR_W-1:0] mem_addr,
    output logic              mem_rd,
    output logic              mem_wr,
    output logic [7:0]        mem_wdata,
    input  logic              mem_ack
);
    logic locked;      // a transfer owns the bus
    logic gnt_data;
    logic data_req;
    logic sel_data;

    assign data_req  = data_rd || data_wr;
    assign sel_data  = locked ? gnt_data : data_req;

    assign mem_addr  = sel_data ? data_addr : fetch_addr;
    assign mem_rd    = sel_data ? data_rd : fetch_req;
    assign mem_wr    = sel_data && data_wr;
    assign mem_wdata = data_wdata;
    assign data_ack  = mem_ack && sel_data;
    assign fetch_ack = mem_ack && !sel_data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            locked   <= 1'b0;
            gnt_data <= 1'b0;
        end else if (locked) begin
            if (mem_ack) begin
                locked <= 1'b0;
            end
        end else if ((data_req || fetch_req) && !mem_ack) begin
            locked   <= 1'b1;
            gnt_data <= data_req;
        end
    end

endmodule

//--- cpu900_top.sv
// ------------------------------
// core top level, one byte-wide memory bus plus register dump
// ------------------------------
`timescale 1ns/1ps
module cpu900_top #(
    parameter int ADDR_W = 16
) (
    input  logic              clk,
    input  logic              rst,
    output logic [ADDR_W-1:0] mem_addr,
    output logic              mem_rd,
    output logic              mem_wr,
    output logic [7:0]        mem_wdata,
    input  logic [7:0]        mem_rdata,
    input  logic              mem_ack,
    output logic              halted,
    input  logic [5:0]        dmp_addr,
    output logic [7:0]        dmp_dout
);
    logic                fetch_req;
    logic [ADDR_W-1:0]   fetch_addr;
    logic                fetch_ack;
    logic                q_valid;
    logic [7:0]          q_byte;
    logic                q_pop;
    logic                flush;
    logic [ADDR_W-1:0]   new_pc;
    logic                data_rd;
    logic                data_wr;
    logic [ADDR_W-1:0]   data_addr;
    logic [7:0]          data_wdata;
    logic                data_ack;
    logic                rf_we;
    logic [2:0]          rf_wsel;
    logic [2:0]          rf_asel;
    logic [2:0]          rf_bsel;
    logic [7:0]          rf_wdata;
    logic [7:0]          flag_we;
    logic [7:0]          flag_out;
    logic [7:0]          flag_mask;
    logic [7:0]          flags;
    logic                exff;
    logic                rfp_we;
    logic [1:0]          rfp_in;
    logic [7:0]          op_a;
    logic [7:0]          op_b;
    logic [7:0]          rslt;
    cpu900_pkg::alu_op_e alu_op;

    cpu900_regs i_regs (
        .clk, .rst, .rf_we, .rf_wsel, .rf_asel, .rf_bsel, .rf_wdata,
        .flag_we, .flag_in(flag_out), .exff, .rfp_we, .rfp_in,
        .op_a, .op_b, .flags, .dmp_addr, .dmp_dout
    );

    cpu900_alu i_alu (
        .alu_op, .a(op_a), .b(op_b), .cin(flags[cpu900_pkg::FLAG_C]),
        .rslt, .flag_out, .flag_mask
    );

    cpu900_fetch #(.ADDR_W(ADDR_W)) i_fetch (
        .clk, .rst, .fetch_req, .fetch_addr, .fetch_ack, .rdata(mem_rdata),
        .q_valid, .q_byte, .q_pop, .flush, .new_pc
    );

    cpu900_ctrl #(.ADDR_W(ADDR_W)) i_ctrl (
        .clk, .rst, .q_valid, .q_byte, .q_pop, .flush, .new_pc,
        .data_rd, .data_wr, .data_addr, .data_wdata, .data_ack, .rdata(mem_rdata),
        .rf_we, .rf_wsel, .rf_asel, .rf_bsel, .rf_wdata, .flag_we,
        .alu_op, .rslt, .flag_mask, .exff, .rfp_we, .rfp_in, .halted
    );

    cpu900_bus_arb #(.ADDR_W(ADDR_W)) i_arb (
        .clk, .rst, .fetch_req, .fetch_addr, .fetch_ack,
        .data_rd, .data_wr, .data_addr, .data_wdata, .data_ack,
        .mem_addr, .mem_rd, .mem_wr, .mem_wdata, .mem_ack
    );

endmodule

//--- tb_clkgen.sv
// ------------------------------
// testbench clock, reset at start and on each reset_go pulse
// ------------------------------
`timescale 1ns/1ps
module tb_clkgen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst,
    input  logic reset_go
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        forever begin
            repeat (RST_CYCLES) @(posedge clk);
            #1 rst = 1'b0;
            @(posedge reset_go);
            rst = 1'b1;     // asynchronous assert
        end
    end

endmodule

//--- cpu900_properties.sv
// ------------------------------
// bus arbiter assertions, attached with bind
// ------------------------------
`timescale 1ns/1ps
module cpu900_arb_props #(
    parameter int ADDR_W = 16
) (
    input logic              clk,
    input logic              rst,
    input logic              mem_rd,
    input logic              mem_wr,
    input logic [ADDR_W-1:0] mem_addr,
    input logic              mem_ack,
    input logic              fetch_req,
    input logic              data_rd,
    input logic              data_wr,
    input logic              fetch_ack,
    input logic              data_ack
);
    rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(mem_rd && mem_wr))
        else $error("mem_rd and mem_wr high together");

    // a waiting request keeps its level and address
    addr_hold: assert property (@(posedge clk) disable iff (rst)
        (mem_rd || mem_wr) && !mem_ack |=> (mem_rd || mem_wr) && $stable(mem_addr))
        else $error("request or address changed before mem_ack");

    // each ack goes to one requester, the one still holding its request
    ack_excl: assert property (@(posedge clk) disable iff (rst)
        mem_ack |-> (fetch_ack && !data_ack && fetch_req)
                 || (data_ack && !fetch_ack && (data_rd || data_wr)))
        else $error("mem_ack not routed to exactly one waiting requester");

endmodule

bind cpu900_bus_arb cpu900_arb_props #(.ADDR_W(ADDR_W)) i_arb_props (
    .clk(clk), .rst(rst), .mem_rd(mem_rd), .mem_wr(mem_wr), .mem_addr(mem_addr),
    .mem_ack(mem_ack), .fetch_req(fetch_req), .data_rd(data_rd), .data_wr(data_wr),
    .fetch_ack(fetch_ack), .data_ack(data_ack)
);

//--- tb_cpu900.sv
// ------------------------------
// runs the stim file programs on the core, checks dump and memory
// ------------------------------
`timescale 1ns/1ps
module tb_cpu900;
    localparam int ADDR_W  = 16;
    localparam int MAX_REC = 512;

    logic              clk;
    logic              rst;
    logic              reset_go;
    logic [ADDR_W-1:0] mem_addr;
    logic              mem_rd;
    logic              mem_wr;
    logic [7:0]        mem_wdata;
    logic [7:0]        mem_rdata;
    logic              mem_ack;
    logic              halted;
    logic [5:0]        dmp_addr;
    logic [7:0]        dmp_dout;

    logic [31:0] stim [0:MAX_REC-1];   // kind, addr, value
    logic [7:0]  mem [0:(1 << ADDR_W) - 1];
    logic [31:0] lfsr;
    logic        mem_busy;
    int          ack_wait;
    int          err_count;
    int          test_err;
    int          check_count;
    int          test_count;
    int          limit;
    bit          limit_ready;
    bit          ran;
    string       test_name;

    tb_clkgen #(.PERIOD(40), .RST_CYCLES(3)) i_clkgen (.clk, .rst, .reset_go);

    cpu900_top #(.ADDR_W(ADDR_W)) i_cpu900_top (
        .clk, .rst, .mem_addr, .mem_rd, .mem_wr, .mem_wdata, .mem_rdata,
        .mem_ack, .halted, .dmp_addr, .dmp_dout
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // memory model, 0 to 3 idle cycles before each ack
    always @(posedge clk) begin
        logic       ack_next;
        logic [7:0] rd_next;
        ack_next = 1'b0;
        rd_next  = mem_rdata;
        if (rst || mem_ack) begin
            mem_busy = 1'b0;
        end else if (mem_rd || mem_wr) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                ack_wait = {30'd0, lfsr[0], 1'b0};
                lfsr     = lfsr_step(lfsr);
                ack_wait = ack_wait | lfsr[0];
                lfsr     = lfsr_step(lfsr);
            end
            if (ack_wait == 0) begin
                ack_next = 1'b1;
                if (mem_wr) begin
                    mem[mem_addr] = mem_wdata;
                end else begin
                    rd_next = mem[mem_addr];
                end
            end else begin
                ack_wait--;
            end
        end
        #1;
        mem_ack   = ack_next;
        mem_rdata = rd_next;
    end

    task automatic check_value(input string label, input logic [7:0] exp,
                               input logic [7:0] act);
        check_count++;
        if (act !== exp) begin
            $display("CHECK FAILED %s %s expected %02h actual %02h",
                     test_name, label, exp, act);
            err_count++;
            test_err++;
        end
    endtask

    task automatic start_test(input logic [15:0] code);
        test_name = $sformatf("test_%04h", code);
        test_err  = 0;
        ran       = 1'b0;
        test_count++;
        @(posedge clk);
        #1 reset_go = 1'b1;
        #1 reset_go = 1'b0;
        for (int i = 0; i < (1 << ADDR_W); i++) begin
            mem[i] = 8'(i) ^ {i[11:8], i[15:12]} ^ 8'h3c;   // background fill
        end
    endtask

    task automatic settle_run();
        if (!ran) begin
            wait (rst === 1'b0);
            wait (halted === 1'b1);
            ran = 1'b1;
        end
    endtask

    task automatic dump_read(input logic [5:0] a, output logic [7:0] v);
        @(posedge clk);
        #1 dmp_addr = a;
        @(posedge clk);
        v = dmp_dout;
    endtask

    initial begin
        int         idx;
        int         n_bytes;
        logic [31:0] rec;
        logic [7:0]  got;
        mem_ack     = 1'b0;
        mem_rdata   = 8'h00;
        dmp_addr    = 6'd0;
        reset_go    = 1'b0;
        mem_busy    = 1'b0;
        ack_wait    = 0;
        lfsr        = 32'h78d7_7181;
        err_count   = 0;
        check_count = 0;
        test_count  = 0;
        n_bytes     = 0;
        idx         = 0;
        for (int i = 0; i < MAX_REC; i++) begin
            stim[i] = 32'h0;
        end
        $readmemh("cpu900_stim.hex", stim);
        for (int i = 0; i < MAX_REC; i++) begin
            if (stim[i][31:24] == 8'h02) n_bytes++;
        end
        limit       = 60 * n_bytes + 200;
        limit_ready = 1'b1;
        wait (rst === 1'b0);
        while (idx < MAX_REC && stim[idx][31:24] != 8'h00) begin
            rec = stim[idx];
            idx++;
            case (rec[31:24])
                8'h01: start_test(rec[23:8]);
                8'h02: mem[rec[23:8]] = rec[7:0];
                8'h03: begin
                    settle_run();
                    dump_read(rec[13:8], got);
                    check_value($sformatf("dump %0d", rec[13:8]), rec[7:0], got);
                end
                8'h04: begin
                    settle_run();
                    check_value($sformatf("mem %04h", rec[23:8]), rec[7:0], mem[rec[23:8]]);
                end
                8'h05: begin
                    settle_run();
                    $display("%s %s, %0d mismatches", test_name,
                             (test_err == 0) ? "ok" : "failed", test_err);
                end
                default: begin
                    $display("unknown stim record %08h", rec);
                    err_count++;
                end
            endcase
        end
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        wait (limit_ready);
        repeat (limit) @(posedge clk);
        $display("timeout, the programs did not finish within %0d cycles", limit);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- build.f
cpu900_pkg.sv
cpu900_regs.sv
cpu900_alu.sv
cpu900_fetch.sv
cpu900_ctrl.sv
cpu900_bus_arb.sv
cpu900_top.sv
tb_clkgen.sv
cpu900_properties.sv
tb_cpu900.sv

//--- Bender.yml
package:
  name: cpu900

sources:
  - cpu900_pkg.sv
  - cpu900_regs.sv
  - cpu900_alu.sv
  - cpu900_fetch.sv
  - cpu900_ctrl.sv
  - cpu900_bus_arb.sv
  - cpu900_top.sv
  - target: test
    files:
      - tb_clkgen.sv
      - cpu900_properties.sv
      - tb_cpu900.sv

//--- cpu900_stim.hex
// kind(8) addr(16) value(8): 01 start with name code, 02 preload byte,
// 03 expect dump value, 04 expect memory byte, 05 end of test
// LD r,#n and LD r,r'
01000100 02000000 0200015A 02000203 020003C3 0200040F 02000500 02000609
02000703 02000870 0300005A 030003C3 0300075A 030001C3 03000200 03002000 05000000
// ADD with overflow, then with carry out to zero
01000200 02000000 0200017F 02000201 02000301 02000410 02000501 02000602
020007FF 02000803 02000901 02000A12 02000B03 02000C70
03000080 03000101 03000200 03000301 03002051 05000000
// SUB with borrow, INC and DEC keep C
01000300 02000000 02000110 02000201 02000320 02000418 02000501 02000639
02000702 02000880 02000942 02000A03 02000B7F 02000C3B 02000D70
030000F0 03000121 0300027F 03000380 03002095 05000000
// AND, OR, XOR with parity in V
01000400 02000000 020001F0 02000201 0200033C 02000420 02000501 02000602
0200070F 0200082A 02000901 02000A04 02000B01 02000C2C 02000D01 02000E03
02000F3C 02001033 02001101 02001270
03000030 0300013C 0300023F 03000300 0300043D 03002044 05000000
// LDRFP bank 2, EXF swap and swap back
01000500 02000000 02000111 02000260 02000302 02000405 020005A5 02000600
0200077F 02000801 02000901 02000A10 02000B01 02000C68 02000D03 02000E00
02000F43 02001068 02001170
03000011 030015A5 03001080 03001101 030013FF 03000500 03002094 03002102 05000000
// ST and LD through the data port
01000600 02000000 020001C7 02000250 02000300 02000402 02000549 02000600
02000703 02000839 02000951 02000A01 02000B02 02000C4A 02000D00 02000E02
02000F70 0203003E
030000C7 0300013F 030002C7 03002000 040200C7 0402013F 05000000
// JP over bytes that would overwrite r0 and r1
01000700 02000000 02000101 02000258 02000310 02000400 02000501 020006EE
02000700 020008EE 02000970 02001002 02001133 02001238 02001370
03000002 03000100 03000233 05000000
